// ==== logic/cart_pkg.sv ====
package cart_pkg;

   //////////////////////////////////////////////////
   // Widths and address constants
   //////////////////////////////////////////////////
   localparam int SNES_AW = 24;
   localparam int SRAM_BW = 22;
   localparam int SLOTS_PER_PHASE = 5;
   localparam int DIRECT_LEN = 4;
   // Save RAM sits in the last 64 KB of chip 3
   localparam logic [SRAM_BW-1:0] SAVE_BASE = 22'h3F_0000;

   //////////////////////////////////////////////////
   // Enums
   //////////////////////////////////////////////////
   typedef enum logic {
      MAP_LOROM = 1'b0,
      MAP_HIROM = 1'b1
   } map_e;

   typedef enum logic [7:0] {
      OP_SET_ADDR   = 8'h10,
      OP_SET_MAPPER = 8'h20,
      OP_WRITE      = 8'h90,
      OP_READ       = 8'hA0
   } avr_op_e;

   typedef enum logic [1:0] {
      SEQ_IDLE,
      SEQ_SNES,
      SEQ_AVR,
      SEQ_WAIT
   } seq_state_e;

   //////////////////////////////////////////////////
   // Bundles
   //////////////////////////////////////////////////
   typedef struct packed {
      logic [SNES_AW-1:0] addr;
      logic               rd_n;
      logic               wr_n;
      logic               cs_n;
   } snes_bus_t;

   typedef struct packed {
      logic [SRAM_BW-1:0] addr;
      logic [7:0]         wdata;
      logic               rd;
      logic               wr;
   } avr_req_t;

   typedef struct packed {
      logic [SRAM_BW-1:0] addr;
      logic               oe_n;
      logic               we_n;
      logic [3:0]         cs_n;
      logic               bhe_n;
      logic               ble_n;
   } sram_ctl_t;

   // One-cycle capture pulses for data_path
   typedef struct packed {
      logic snes_to_mem;
      logic avr_to_mem;
      logic mem_to_snes;
      logic mem_to_avr;
   } latch_t;

endpackage

// ==== logic/spi_slave.sv ====
`timescale 1ns/100ps

module spi_slave (
   input  logic       CLK2,
   input  logic       arst_n,
   input  logic       sck,
   input  logic       mosi,
   input  logic       ss_n,
   input  logic [7:0] tx_byte,
   output logic       miso,
   output logic [7:0] rx_byte,
   output logic       cmd_strobe,
   output logic       param_strobe,
   output logic       msg_start
);

   // Two sync flops plus one history flop for edge detection
   logic [2:0] sck_sr;
   logic [2:0] ss_sr;
   logic       sck_rise;
   logic       sck_fall;
   logic       ss_fall;
   logic       ss_act;
   logic [2:0] bit_cnt;
   logic [7:0] rx_sr;
   logic [7:0] tx_sr;
   logic       first;

   assign sck_rise = sck_sr[1] & ~sck_sr[2];
   assign sck_fall = ~sck_sr[1] & sck_sr[2];
   assign ss_fall  = ~ss_sr[1] & ss_sr[2];
   assign ss_act   = ~ss_sr[1];
   assign miso     = tx_sr[7];

   always_ff @(posedge CLK2 or negedge arst_n) begin
      if (!arst_n) begin
         sck_sr <= 3'b000;
         ss_sr <= 3'b111;
      end else begin
         sck_sr <= {sck_sr[1:0], sck};
         ss_sr <= {ss_sr[1:0], ss_n};
      end
   end

   always_ff @(posedge CLK2 or negedge arst_n) begin
      if (!arst_n) begin
         bit_cnt <= 3'd0;
         rx_sr <= 8'h00;
         tx_sr <= 8'h00;
         rx_byte <= 8'h00;
         first <= 1'b0;
         cmd_strobe <= 1'b0;
         param_strobe <= 1'b0;
         msg_start <= 1'b0;
      end else begin
         cmd_strobe <= 1'b0;
         param_strobe <= 1'b0;
         msg_start <= ss_fall;
         if (!ss_act) begin
            bit_cnt <= 3'd0;
         end else begin
            if (ss_fall) begin
               first <= 1'b1;
               tx_sr <= tx_byte;
            end
            // Mode 0: sample on rising SCK, shift out on falling SCK
            if (sck_rise) begin
               rx_sr <= {rx_sr[6:0], mosi};
               bit_cnt <= bit_cnt + 3'd1;
               if (bit_cnt == 3'd7) begin
                  rx_byte <= {rx_sr[6:0], mosi};
                  cmd_strobe <= first;
                  param_strobe <= ~first;
                  first <= 1'b0;
                  tx_sr <= tx_byte;
               end
            end else if (sck_fall && bit_cnt != 3'd0) begin
               // Trailing fall of a byte keeps the freshly loaded MSB
               tx_sr <= {tx_sr[6:0], 1'b0};
            end
         end
      end
   end

endmodule

// ==== logic/avr_cmd.sv ====
`timescale 1ns/100ps

module avr_cmd (
   input  logic              CLK2,
   input  logic              arst_n,
   input  logic [7:0]        rx_byte,
   input  logic              cmd_strobe,
   input  logic              param_strobe,
   input  logic              msg_start,
   input  logic              avr_done,
   input  logic [7:0]        rd_byte,
   output cart_pkg::avr_req_t req,
   output cart_pkg::map_e    mapper,
   output logic [7:0]        tx_byte
);

   import cart_pkg::*;

   avr_op_e    op;
   logic       op_valid;
   logic [1:0] pcnt;
   logic       done_q;

   //////////////////////////////////////////////////
   // Command and parameter decode
   //////////////////////////////////////////////////
   always_ff @(posedge CLK2 or negedge arst_n) begin
      if (!arst_n) begin
         op <= OP_SET_ADDR;
         op_valid <= 1'b0;
         pcnt <= 2'd0;
         req <= '0;
         mapper <= MAP_LOROM;
      end else begin
         if (msg_start) begin
            op_valid <= 1'b0;
            pcnt <= 2'd0;
         end
         if (cmd_strobe) begin
            op <= avr_op_e'(rx_byte);
            op_valid <= 1'b1;
            pcnt <= 2'd0;
         end
         if (param_strobe && op_valid) begin
            if (pcnt != 2'd3) begin
               pcnt <= pcnt + 2'd1;
            end
            case (op)
               OP_SET_ADDR: begin
                  // Most significant byte first, top two bits dropped
                  case (pcnt)
                     2'd0:    req.addr[21:16] <= rx_byte[5:0];
                     2'd1:    req.addr[15:8] <= rx_byte;
                     2'd2:    req.addr[7:0] <= rx_byte;
                     default: ;
                  endcase
               end
               OP_SET_MAPPER: mapper <= map_e'(rx_byte[0]);
               OP_WRITE: begin
                  req.wdata <= rx_byte;
                  req.wr <= 1'b1;
               end
               OP_READ: req.rd <= 1'b1;
               default: ;
            endcase
         end
         // Request level drops and address steps once serviced
         if (avr_done) begin
            req.rd <= 1'b0;
            req.wr <= 1'b0;
            req.addr <= req.addr + 1'b1;
         end
      end
   end

   // Read byte lands in data_path one clock after done in shared mode
   always_ff @(posedge CLK2 or negedge arst_n) begin
      if (!arst_n) begin
         done_q <= 1'b0;
         tx_byte <= 8'h00;
      end else begin
         done_q <= avr_done;
         if (done_q && op == OP_READ) begin
            tx_byte <= rd_byte;
         end
      end
   end

endmodule

// ==== logic/addr_map.sv ====
`timescale 1ns/100ps

module addr_map (
   input  logic                         CLK2,
   input  logic                         arst_n,
   input  cart_pkg::snes_bus_t          bus,
   input  cart_pkg::map_e               mapper,
   input  logic [cart_pkg::SRAM_BW-1:0] avr_addr,
   input  logic                         phase_avr,
   output logic [cart_pkg::SRAM_BW-1:0] sram_addr,
   output logic [3:0]                   cs_n,
   output logic                         is_rom,
   output logic                         is_save
);

   import cart_pkg::*;

   logic [7:0]         bank;
   logic               lo_save;
   logic               hi_save;
   logic               rom;
   logic               save;
   logic [SRAM_BW-1:0] save_off;
   logic [SRAM_BW-1:0] rom_off;
   logic [SRAM_BW-1:0] sel_addr;

   assign bank = bus.addr[23:16];

   // LoROM save RAM in banks 70-7D, lower half
   assign lo_save = (bank >= 8'h70) && (bank <= 8'h7D) && !bus.addr[15];
   // HiROM save RAM at 6000-7FFF of banks 20-3F
   assign hi_save = (bank >= 8'h20) && (bank <= 8'h3F) && (bus.addr[15:13] == 3'b011);

   assign save = (mapper == MAP_HIROM) ? hi_save : lo_save;
   assign rom  = (mapper == MAP_HIROM) ? (bus.addr[22] | bus.addr[15]) : bus.addr[15];

   assign save_off = SAVE_BASE + {9'd0, bus.addr[12:0]};
   assign rom_off  = (mapper == MAP_HIROM) ? bus.addr[21:0]
                                           : {bus.addr[22:16], bus.addr[14:0]};

   assign sel_addr = phase_avr ? avr_addr : (save ? save_off : rom_off);

   always_ff @(posedge CLK2 or negedge arst_n) begin
      if (!arst_n) begin
         sram_addr <= '0;
         cs_n <= 4'hF;
         is_rom <= 1'b0;
         is_save <= 1'b0;
      end else begin
         sram_addr <= sel_addr;
         // One chip per 1 MB, picked by the top two bits
         cs_n <= ~(4'b0001 << sel_addr[SRAM_BW-1 -: 2]);
         is_rom <= rom & ~save;
         is_save <= save;
      end
   end

endmodule

// ==== logic/bus_sequencer.sv ====
`timescale 1ns/100ps

module bus_sequencer (
   input  logic                CLK2,
   input  logic                arst_n,
   input  cart_pkg::snes_bus_t bus,
   input  logic                avr_ena,
   input  cart_pkg::avr_req_t  req,
   input  logic                is_rom,
   input  logic                is_save,
   input  logic                lane,
   output logic                oe_n,
   output logic                we_n,
   output logic                bhe_n,
   output logic                ble_n,
   output cart_pkg::latch_t    latch,
   output logic                phase_avr,
   output logic                avr_done,
   output logic                snes_oe_n,
   output logic                snes_dir
);

   import cart_pkg::*;

   seq_state_e state;
   logic [3:0] slot;
   logic [2:0] dcnt;
   logic       rw_idle;
   logic       rw_idle_q;
   logic       start;
   logic       snes_rd_cyc;
   logic       snes_wr_cyc;
   logic       avr_rd_cyc;
   logic       avr_wr_cyc;
   logic       snes_ph;
   logic       avr_ph;
   logic       s_we;
   logic       s_oe;
   logic       a_we;
   logic       a_oe;
   logic       d_we;
   logic       d_oe;

   assign rw_idle = bus.rd_n & bus.wr_n;
   // New SNES cycle: /RD or /WR falls after both were high
   assign start = (state == SEQ_IDLE) && avr_ena && rw_idle_q && !rw_idle;

   //////////////////////////////////////////////////
   // Slot FSM
   //////////////////////////////////////////////////
   always_ff @(posedge CLK2 or negedge arst_n) begin
      if (!arst_n) begin
         state <= SEQ_IDLE;
         slot <= 4'd0;
         rw_idle_q <= 1'b1;
         snes_rd_cyc <= 1'b0;
         snes_wr_cyc <= 1'b0;
         avr_rd_cyc <= 1'b0;
         avr_wr_cyc <= 1'b0;
      end else begin
         rw_idle_q <= rw_idle;
         case (state)
            SEQ_IDLE: begin
               if (start) begin
                  state <= SEQ_SNES;
                  slot <= 4'd0;
                  snes_rd_cyc <= ~bus.rd_n;
                  snes_wr_cyc <= ~bus.wr_n;
                  avr_rd_cyc <= req.rd;
                  avr_wr_cyc <= req.wr;
               end
            end
            SEQ_SNES: begin
               slot <= slot + 4'd1;
               if (slot == 4'(SLOTS_PER_PHASE - 1)) begin
                  state <= SEQ_AVR;
               end
            end
            SEQ_AVR: begin
               slot <= slot + 4'd1;
               if (slot == 4'(2 * SLOTS_PER_PHASE - 1)) begin
                  state <= SEQ_WAIT;
               end
            end
            default: begin
               // Hold until the SNES releases the bus
               if (rw_idle) begin
                  state <= SEQ_IDLE;
               end
            end
         endcase
      end
   end

   // Direct mode counter, the AVR owns the SRAM
   always_ff @(posedge CLK2 or negedge arst_n) begin
      if (!arst_n) begin
         dcnt <= 3'd0;
      end else if (avr_ena) begin
         dcnt <= 3'd0;
      end else if (dcnt == 3'(DIRECT_LEN)) begin
         dcnt <= 3'd0;
      end else if (dcnt != 3'd0 || req.rd || req.wr) begin
         dcnt <= dcnt + 3'd1;
      end
   end

   //////////////////////////////////////////////////
   // Strobe and latch tables
   //////////////////////////////////////////////////
   assign snes_ph = (state == SEQ_SNES);
   assign avr_ph  = (state == SEQ_AVR);

   // SNES writes outside save RAM never reach the SRAM
   assign s_we = snes_ph && snes_wr_cyc && is_save && (slot inside {[4'd1:4'd3]});
   assign s_oe = snes_ph && snes_rd_cyc && (is_rom || is_save) && (slot inside {[4'd1:4'd4]});
   assign a_we = avr_ph && avr_wr_cyc && (slot inside {[4'd6:4'd8]});
   assign a_oe = avr_ph && avr_rd_cyc && (slot inside {[4'd6:4'd9]});
   assign d_we = req.wr && (dcnt inside {[3'd1:3'd3]});
   assign d_oe = req.rd && (dcnt inside {[3'd1:3'd3]});

   assign we_n  = ~(s_we | a_we | d_we);
   assign oe_n  = ~(s_oe | a_oe | d_oe);
   assign bhe_n = ~((~we_n | ~oe_n) & lane);
   assign ble_n = ~((~we_n | ~oe_n) & ~lane);

   assign latch.snes_to_mem = snes_ph && snes_wr_cyc && (slot == 4'd0);
   assign latch.mem_to_snes = snes_ph && snes_rd_cyc && (slot == 4'd4);
   assign latch.avr_to_mem  = (avr_ph && avr_wr_cyc && (slot == 4'd5))
                            || (req.wr && dcnt == 3'd1);
   assign latch.mem_to_avr  = (avr_ph && avr_rd_cyc && (slot == 4'd9))
                            || (req.rd && dcnt == 3'd3);

   assign avr_done = (avr_ph && (avr_rd_cyc || avr_wr_cyc) && (slot == 4'd9))
                   || (dcnt == 3'(DIRECT_LEN));

   // Switch the address one slot early, addr_map adds a register
   assign phase_avr = ~avr_ena | avr_ph | (snes_ph && slot == 4'(SLOTS_PER_PHASE - 1));

   assign snes_oe_n = ~(((~bus.cs_n & is_rom) | is_save) & ~rw_idle);
   assign snes_dir  = bus.wr_n;

endmodule

// ==== logic/data_path.sv ====
`timescale 1ns/100ps

module data_path (
   input  logic             CLK2,
   input  logic             arst_n,
   input  cart_pkg::latch_t latch,
   input  logic             lane,
   input  logic [7:0]       snes_data_in,
   input  logic [7:0]       avr_wdata,
   input  logic [15:0]      sram_rdata,
   output logic [15:0]      sram_wdata,
   output logic [7:0]       snes_data_out,
   output logic [7:0]       avr_rdata
);

   logic [7:0] wr_q;
   logic [7:0] rd_sel;

   // Odd addresses live in the upper byte of each word
   assign rd_sel = lane ? sram_rdata[15:8] : sram_rdata[7:0];

   // Byte enables pick the lane, so drive both halves
   assign sram_wdata = {wr_q, wr_q};

   always_ff @(posedge CLK2 or negedge arst_n) begin
      if (!arst_n) begin
         wr_q <= 8'h00;
         snes_data_out <= 8'h00;
         avr_rdata <= 8'h00;
      end else begin
         if (latch.snes_to_mem) begin
            wr_q <= snes_data_in;
         end else if (latch.avr_to_mem) begin
            wr_q <= avr_wdata;
         end
         if (latch.mem_to_snes) begin
            snes_data_out <= rd_sel;
         end
         if (latch.mem_to_avr) begin
            avr_rdata <= rd_sel;
         end
      end
   end

endmodule

// ==== logic/cart_top.sv ====
`timescale 1ns/100ps

module cart_top (
   input  logic                         CLK2,
   input  logic                         arst_n,
   input  logic [cart_pkg::SNES_AW-1:0] snes_addr,
   input  logic                         snes_rd_n,
   input  logic                         snes_wr_n,
   input  logic                         snes_cs_n,
   input  logic [7:0]                   snes_data_in,
   input  logic [15:0]                  sram_rdata,
   input  logic                         spi_sck,
   input  logic                         spi_mosi,
   input  logic                         spi_ss_n,
   input  logic                         avr_ena,
   output logic [7:0]                   snes_data_out,
   output logic                         snes_oe_n,
   output logic                         snes_dir,
   output cart_pkg::sram_ctl_t          sram,
   output logic [15:0]                  sram_wdata,
   output logic                         spi_miso
);

   import cart_pkg::*;

   snes_bus_t          bus;
   logic               avr_ena_q;
   avr_req_t           req;
   map_e               mapper;
   latch_t             latch;
   logic [7:0]         rx_byte;
   logic [7:0]         tx_byte;
   logic [7:0]         avr_rdata;
   logic               cmd_strobe;
   logic               param_strobe;
   logic               msg_start;
   logic               avr_done;
   logic               phase_avr;
   logic               is_rom;
   logic               is_save;
   logic [SRAM_BW-1:0] sram_addr;
   logic [3:0]         cs_n;
   logic               oe_n;
   logic               we_n;
   logic               bhe_n;
   logic               ble_n;

   //////////////////////////////////////////////////
   // Input synchronizers
   //////////////////////////////////////////////////
   always_ff @(posedge CLK2 or negedge arst_n) begin
      if (!arst_n) begin
         bus <= '{addr: '0, rd_n: 1'b1, wr_n: 1'b1, cs_n: 1'b1};
         avr_ena_q <= 1'b1;
      end else begin
         bus <= '{addr: snes_addr, rd_n: snes_rd_n, wr_n: snes_wr_n, cs_n: snes_cs_n};
         avr_ena_q <= avr_ena;
      end
   end

   assign sram = '{addr: sram_addr, oe_n: oe_n, we_n: we_n, cs_n: cs_n,
                   bhe_n: bhe_n, ble_n: ble_n};

   //////////////////////////////////////////////////
   // Blocks
   //////////////////////////////////////////////////
   spi_slave i_spi_slave (
      .CLK2(CLK2), .arst_n(arst_n), .sck(spi_sck), .mosi(spi_mosi), .ss_n(spi_ss_n),
      .tx_byte(tx_byte), .miso(spi_miso), .rx_byte(rx_byte), .cmd_strobe(cmd_strobe),
      .param_strobe(param_strobe), .msg_start(msg_start)
   );

   avr_cmd i_avr_cmd (
      .CLK2(CLK2), .arst_n(arst_n), .rx_byte(rx_byte), .cmd_strobe(cmd_strobe),
      .param_strobe(param_strobe), .msg_start(msg_start), .avr_done(avr_done),
      .rd_byte(avr_rdata), .req(req), .mapper(mapper), .tx_byte(tx_byte)
   );

   addr_map i_addr_map (
      .CLK2(CLK2), .arst_n(arst_n), .bus(bus), .mapper(mapper), .avr_addr(req.addr),
      .phase_avr(phase_avr), .sram_addr(sram_addr), .cs_n(cs_n), .is_rom(is_rom),
      .is_save(is_save)
   );

   bus_sequencer i_bus_sequencer (
      .CLK2(CLK2), .arst_n(arst_n), .bus(bus), .avr_ena(avr_ena_q), .req(req),
      .is_rom(is_rom), .is_save(is_save), .lane(sram_addr[0]), .oe_n(oe_n), .we_n(we_n),
      .bhe_n(bhe_n), .ble_n(ble_n), .latch(latch), .phase_avr(phase_avr),
      .avr_done(avr_done), .snes_oe_n(snes_oe_n), .snes_dir(snes_dir)
   );

   data_path i_data_path (
      .CLK2(CLK2), .arst_n(arst_n), .latch(latch), .lane(sram_addr[0]),
      .snes_data_in(snes_data_in), .avr_wdata(req.wdata), .sram_rdata(sram_rdata),
      .sram_wdata(sram_wdata), .snes_data_out(snes_data_out), .avr_rdata(avr_rdata)
   );

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock #(
   parameter int PERIOD_NS = 100,
   parameter int RST_CYCLES = 5
) (
   output logic CLK2,
   output logic arst_n
);

   initial begin
      CLK2 = 1'b0;
      forever #(PERIOD_NS / 2) CLK2 = ~CLK2;
   end

   initial begin
      arst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge CLK2);
      arst_n <= 1'b1;
   end

endmodule

// ==== test/sram_model.sv ====
`timescale 1ns/100ps

module sram_model (
   input  logic                CLK2,
   input  cart_pkg::sram_ctl_t sram,
   input  logic [15:0]         wdata,
   output logic [15:0]         rdata
);

   // Four chips of 512K words, index is {chip, word address}
   logic [15:0] mem [0:2**21-1];
   logic        sel_ok;
   logic [1:0]  chip;
   logic [20:0] idx;

   always_comb begin
      sel_ok = 1'b1;
      chip = 2'd0;
      case (sram.cs_n)
         4'b1110: chip = 2'd0;
         4'b1101: chip = 2'd1;
         4'b1011: chip = 2'd2;
         4'b0111: chip = 2'd3;
         default: sel_ok = 1'b0;
      endcase
      idx = {chip, sram.addr[19:1]};
   end

   assign rdata = (sel_ok && !sram.oe_n) ? mem[idx] : 16'h0000;

   // Level sensitive write, sampled mid cycle
   always @(negedge CLK2) begin
      if (sel_ok && !sram.we_n) begin
         if (!sram.ble_n) mem[idx][7:0] <= wdata[7:0];
         if (!sram.bhe_n) mem[idx][15:8] <= wdata[15:8];
      end
   end

endmodule

// ==== test/cart_sva.sv ====
`timescale 1ns/100ps

module cart_sva (
   input logic CLK2,
   input logic arst_n,
   input logic oe_n,
   input logic we_n,
   input logic avr_done,
   input logic snes_ph,
   input logic snes_wr_cyc,
   input logic is_save
);

   // Failure count, read by the testbench at the end of the run
   int fail_cnt = 0;

   strobe_excl: assert property (@(posedge CLK2) disable iff (!arst_n) !(!oe_n && !we_n))
      else begin
         fail_cnt++;
         $error("oe_n and we_n are low together");
      end

   done_width: assert property (@(posedge CLK2) disable iff (!arst_n) avr_done |=> !avr_done)
      else begin
         fail_cnt++;
         $error("avr_done is wider than one cycle");
      end

   // ROM stays read only for the SNES
   rom_protect: assert property (@(posedge CLK2) disable iff (!arst_n)
      (snes_ph && snes_wr_cyc && !is_save) |-> we_n)
      else begin
         fail_cnt++;
         $error("we_n low for a SNES write outside save RAM");
      end

endmodule

bind bus_sequencer cart_sva i_cart_sva (
   .CLK2(CLK2), .arst_n(arst_n), .oe_n(oe_n), .we_n(we_n), .avr_done(avr_done),
   .snes_ph(snes_ph), .snes_wr_cyc(snes_wr_cyc), .is_save(is_save)
);

// ==== test/cart_tb.sv ====
`timescale 1ns/100ps

module cart_tb;

   import cart_pkg::*;

   localparam int N_DIRECT = 32;
   localparam int N_ROM = 8;
   localparam int N_SAVE = 4;
   localparam int N_SHARED = 8;
   localparam int BYTE_CLKS = 8 * 16;
   localparam int MSG_CLKS = 56;
   localparam int SNES_CLKS = 16;
   localparam int SPI_BYTES = (4 + N_DIRECT + 1) + (4 + N_DIRECT + 3) + 2
                            + (4 + N_SHARED + 1) + (4 + N_SHARED + 3);
   localparam int MSGS = 9;
   localparam int SNES_OPS = 2 * N_ROM + 2 * N_SAVE + 4 + 1;
   localparam int TOTAL_CLKS = 40 + SPI_BYTES * BYTE_CLKS + MSGS * MSG_CLKS
                             + SNES_OPS * SNES_CLKS;
   localparam longint WATCHDOG_NS = longint'(TOTAL_CLKS) * 100 * 12 / 10;

   logic              CLK2;
   logic              arst_n;
   logic [23:0]       snes_addr;
   logic              snes_rd_n;
   logic              snes_wr_n;
   logic              snes_cs_n;
   logic [7:0]        snes_data_in;
   logic [15:0]       sram_rdata;
   logic              spi_sck;
   logic              spi_mosi;
   logic              spi_ss_n;
   logic              avr_ena;
   logic [7:0]        snes_data_out;
   logic              snes_oe_n;
   logic              snes_dir;
   sram_ctl_t         sram;
   logic [15:0]       sram_wdata;
   logic              spi_miso;

   logic [7:0]        shadow [0:2**22-1];
   logic [7:0]        tx_buf [0:63];
   logic [7:0]        rx_buf [0:63];
   logic [31:0]       exp_q[$];
   logic [31:0]       got_q[$];
   string             name_q[$];
   logic [23:0]       rom_addr [0:N_ROM-1];
   int                errors;
   int                checks;
   int                sva_fails;
   integer            seed;
   map_e              cur_map;
   logic              snes_stop;

   tb_clock #(.PERIOD_NS(100), .RST_CYCLES(5)) i_tb_clock (.CLK2(CLK2), .arst_n(arst_n));

   cart_top i_cart_top (
      .CLK2(CLK2), .arst_n(arst_n), .snes_addr(snes_addr), .snes_rd_n(snes_rd_n),
      .snes_wr_n(snes_wr_n), .snes_cs_n(snes_cs_n), .snes_data_in(snes_data_in),
      .sram_rdata(sram_rdata), .spi_sck(spi_sck), .spi_mosi(spi_mosi), .spi_ss_n(spi_ss_n),
      .avr_ena(avr_ena), .snes_data_out(snes_data_out), .snes_oe_n(snes_oe_n),
      .snes_dir(snes_dir), .sram(sram), .sram_wdata(sram_wdata), .spi_miso(spi_miso)
   );

   sram_model i_sram_model (.CLK2(CLK2), .sram(sram), .wdata(sram_wdata), .rdata(sram_rdata));

   //////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////
   // Returns {rom, save, byte offset}
   function automatic logic [23:0] snes_to_sram(input logic [23:0] a, input map_e m);
      logic       rom;
      logic       save;
      logic [7:0] bank;
      bank = a[23:16];
      if (m == MAP_LOROM) begin
         save = (bank >= 8'h70) && (bank <= 8'h7D) && !a[15];
         rom = a[15];
      end else begin
         save = (bank >= 8'h20) && (bank <= 8'h3F) && (a[15:13] == 3'b011);
         rom = a[22] | a[15];
      end
      if (save) return {1'b0, 1'b1, 22'h3F_0000 + {9'd0, a[12:0]}};
      if (m == MAP_LOROM) return {rom, 1'b0, a[22:16], a[14:0]};
      return {rom, 1'b0, a[21:0]};
   endfunction

   // Scrambled fill so every address bit matters
   function automatic logic [7:0] fill_byte(input logic [21:0] a);
      logic [31:0] h;
      h = {10'd0, a} * 32'h9E37_79B1;
      return h[31:24] ^ a[7:0];
   endfunction

   //////////////////////////////////////////////////
   // Checking
   //////////////////////////////////////////////////
   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL %0t ns %s got %0h expected %0h", $time, name, got, exp);
      end
   endtask

   task automatic expect_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      name_q.push_back(name);
      got_q.push_back(got);
      exp_q.push_back(exp);
   endtask

   initial begin
      forever begin
         wait (got_q.size() > 0);
         check_val(name_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
      end
   end

   task automatic tick(input int n);
      repeat (n) @(posedge CLK2);
   endtask

   task automatic mem_compare();
      int bad;
      bad = 0;
      for (int w = 0; w < 2**21; w++) begin
         if (i_sram_model.mem[w] !== {shadow[2*w+1], shadow[2*w]}) bad++;
      end
      expect_val("sram_mismatches", bad, 0);
   endtask

   //////////////////////////////////////////////////
   // SPI master
   //////////////////////////////////////////////////
   task automatic spi_send(input int n);
      spi_ss_n <= 1'b0;
      tick(16);
      for (int i = 0; i < n; i++) begin
         for (int b = 7; b >= 0; b--) begin
            spi_mosi <= tx_buf[i][b];
            tick(8);
            rx_buf[i][b] = spi_miso;
            spi_sck <= 1'b1;
            tick(8);
            spi_sck <= 1'b0;
         end
      end
      tick(16);
      spi_ss_n <= 1'b1;
      tick(24);
   endtask

   task automatic set_addr(input logic [21:0] a);
      tx_buf[0] = OP_SET_ADDR;
      tx_buf[1] = {2'b00, a[21:16]};
      tx_buf[2] = a[15:8];
      tx_buf[3] = a[7:0];
      spi_send(4);
   endtask

   task automatic avr_write(input logic [21:0] a, input int n);
      set_addr(a);
      tx_buf[0] = OP_WRITE;
      for (int i = 0; i < n; i++) begin
         tx_buf[1+i] = $random(seed);
         shadow[a+i] = tx_buf[1+i];
      end
      spi_send(n + 1);
   endtask

   // Read data trails the request by two SPI bytes
   task automatic avr_read(input logic [21:0] a, input int n);
      set_addr(a);
      tx_buf[0] = OP_READ;
      for (int i = 1; i < n + 3; i++) tx_buf[i] = 8'h00;
      spi_send(n + 3);
      for (int i = 0; i < n; i++) expect_val("spi_miso byte", rx_buf[3+i], shadow[a+i]);
   endtask

   //////////////////////////////////////////////////
   // SNES bus
   //////////////////////////////////////////////////
   task automatic snes_read(input logic [23:0] a);
      logic [23:0] m;
      m = snes_to_sram(a, cur_map);
      snes_addr <= a;
      snes_cs_n <= ~m[23];
      snes_rd_n <= 1'b0;
      tick(8);
      @(negedge CLK2);
      expect_val("snes_oe_n", snes_oe_n, 0);
      expect_val("snes_dir", snes_dir, 1);
      @(posedge CLK2);
      tick(2);
      @(negedge CLK2);
      expect_val("snes_data_out", snes_data_out, shadow[m[21:0]]);
      @(posedge CLK2);
      snes_rd_n <= 1'b1;
      snes_cs_n <= 1'b1;
      tick(2);
      // Data bus released once /RD is back high
      @(negedge CLK2);
      expect_val("snes_oe_n", snes_oe_n, 1);
      @(posedge CLK2);
      tick(1);
   endtask

   task automatic snes_write(input logic [23:0] a, input logic [7:0] d);
      logic [23:0] m;
      m = snes_to_sram(a, cur_map);
      snes_addr <= a;
      snes_cs_n <= ~m[23];
      snes_data_in <= d;
      snes_wr_n <= 1'b0;
      tick(8);
      @(negedge CLK2);
      expect_val("snes_dir", snes_dir, 0);
      @(posedge CLK2);
      tick(3);
      snes_wr_n <= 1'b1;
      snes_cs_n <= 1'b1;
      if (m[22]) shadow[m[21:0]] = d;
      tick(4);
   endtask

   //////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////
   initial begin
      logic [23:0] a;
      snes_addr = 24'h0;
      snes_rd_n = 1'b1;
      snes_wr_n = 1'b1;
      snes_cs_n = 1'b1;
      snes_data_in = 8'h00;
      spi_sck = 1'b0;
      spi_mosi = 1'b0;
      spi_ss_n = 1'b1;
      avr_ena = 1'b0;
      errors = 0;
      checks = 0;
      sva_fails = 0;
      seed = 32'hfddf;
      cur_map = MAP_LOROM;
      snes_stop = 1'b0;
      for (int w = 0; w < 2**21; w++) begin
         shadow[2*w] = fill_byte(22'(2 * w));
         shadow[2*w+1] = fill_byte(22'(2 * w + 1));
         i_sram_model.mem[w] = {shadow[2*w+1], shadow[2*w]};
      end
      wait (arst_n);
      tick(4);

      // Direct mode
      avr_write(22'h12_3450, N_DIRECT);
      avr_read(22'h12_3450, N_DIRECT);
      mem_compare();
      avr_ena <= 1'b1;
      tick(8);

      // LoROM then HiROM over the same addresses
      for (int i = 0; i < N_ROM; i++) begin
         rom_addr[i] = $random(seed) | 24'h00_8000;
         snes_read(rom_addr[i]);
      end
      tx_buf[0] = OP_SET_MAPPER;
      tx_buf[1] = 8'h01;
      spi_send(2);
      cur_map = MAP_HIROM;
      for (int i = 0; i < N_ROM; i++) snes_read(rom_addr[i]);

      // Save RAM writes and ROM write protection
      for (int i = 0; i < N_SAVE; i++) begin
         a = $random(seed);
         a = {3'b001, a[20:16], 3'b011, a[12:0]};
         snes_write(a, $random(seed));
         snes_read(a);
      end
      snes_write(24'hC1_1234, 8'hA5);
      snes_read(24'hC1_1234);
      snes_write(24'h05_9ABC, 8'h3C);
      snes_read(24'h05_9ABC);

      // Shared mode, SNES keeps reading chip 0 ROM
      fork
         begin
            avr_write(22'h2A_BC00, N_SHARED);
            avr_read(22'h2A_BC00, N_SHARED);
            snes_stop = 1'b1;
         end
         begin
            while (!snes_stop) begin
               a = $random(seed);
               snes_read({4'hC, a[19:0]});
            end
         end
      join
      mem_compare();

      wait (got_q.size() == 0);
      tick(2);
      sva_fails = i_cart_top.i_bus_sequencer.i_cart_sva.fail_cnt;
      $display("checks %0d errors %0d assertion failures %0d", checks, errors, sva_fails);
      if (errors == 0 && sva_fails == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns, the test sequence did not finish", WATCHDOG_NS);
      $display("TESTS FAILED");
      $finish;
   end

endmodule

// ==== vlog.f ====
logic/cart_pkg.sv
logic/spi_slave.sv
logic/avr_cmd.sv
logic/addr_map.sv
logic/bus_sequencer.sv
logic/data_path.sv
logic/cart_top.sv
test/tb_clock.sv
test/sram_model.sv
test/cart_sva.sv
test/cart_tb.sv

// ==== Bender.yml ====
package:
  name: cart_ctrl

sources:
  - logic/cart_pkg.sv
  - logic/spi_slave.sv
  - logic/avr_cmd.sv
  - logic/addr_map.sv
  - logic/bus_sequencer.sv
  - logic/data_path.sv
  - logic/cart_top.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/sram_model.sv
      - test/cart_sva.sv
      - test/cart_tb.sv
